/* design/burst_addr_tracker.sv */
// ===========================================================================
// Burst word address tracker
// ===========================================================================

`include "sram_axi4_cfg.svh"

module burst_addr_tracker (
    input  logic                       i_aclk,
    input  logic                       i_areset_n,
    input  logic                       i_load,
    input  sram_axi4_pkg::addr_t       i_addr,
    input  sram_axi4_pkg::len_t        i_len,
    input  sram_axi4_pkg::burst_e      i_burst,
    input  logic                       i_step,
    output sram_axi4_pkg::word_idx_t   o_idx,
    output logic                       o_last
);

    sram_axi4_pkg::word_idx_t r_idx;
    sram_axi4_pkg::len_t      r_len;
    sram_axi4_pkg::len_t      r_cnt;
    sram_axi4_pkg::burst_e    r_burst;

    sram_axi4_pkg::word_idx_t w_idx_inc;
    sram_axi4_pkg::word_idx_t w_idx_next;
    sram_axi4_pkg::word_idx_t w_wrap_mask;

    // Legal wrap lengths are powers of two, so len itself masks the block
    assign w_wrap_mask = sram_axi4_pkg::word_idx_t'(r_len);
    assign w_idx_inc   = r_idx + 1'b1;

    always_comb begin
        case (r_burst)
            sram_axi4_pkg::BURST_FIXED: begin
                w_idx_next = r_idx;
            end
            sram_axi4_pkg::BURST_WRAP: begin
                w_idx_next = (r_idx & ~w_wrap_mask) | (w_idx_inc & w_wrap_mask);
            end
            default: begin
                w_idx_next = w_idx_inc;
            end
        endcase
    end

    // Beat counter
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_cnt <= '0;
        end else if (i_load) begin
            r_cnt <= '0;
        end else if (i_step) begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

    // Burst parameters and current word
    always_ff @(posedge i_aclk) begin
        if (i_load) begin
            r_idx   <= i_addr[`SRAM_ADDR_W-1:`SRAM_ADDR_W-`SRAM_WORD_ADDR_W];
            r_len   <= i_len;
            r_burst <= i_burst;
        end else if (i_step) begin
            r_idx <= w_idx_next;
        end
    end

    assign o_idx  = r_idx;
    assign o_last = (r_cnt == r_len);

endmodule

/* design/sram_axi4.sv */
// ===========================================================================
// 2 KB SRAM with AXI4 slave port
// ===========================================================================

`include "sram_axi4_cfg.svh"

module sram_axi4 (
    input  logic                    i_aclk,
    input  logic                    i_areset_n,
    // Read address
    input  sram_axi4_pkg::id_t      i_arid,
    input  sram_axi4_pkg::addr_t    i_araddr,
    input  sram_axi4_pkg::len_t     i_arlen,
    input  sram_axi4_pkg::burst_e   i_arburst,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    // Read data
    output sram_axi4_pkg::id_t      o_rid,
    output sram_axi4_pkg::data_t    o_rdata,
    output logic                    o_rlast,
    output logic                    o_rvalid,
    input  logic                    i_rready,
    // Write address
    input  sram_axi4_pkg::id_t      i_awid,
    input  sram_axi4_pkg::addr_t    i_awaddr,
    input  sram_axi4_pkg::len_t     i_awlen,
    input  sram_axi4_pkg::burst_e   i_awburst,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    // Write data
    input  sram_axi4_pkg::data_t    i_wdata,
    input  sram_axi4_pkg::strb_t    i_wstrb,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    // Write response
    output sram_axi4_pkg::id_t      o_bid,
    output logic                    o_bvalid,
    input  logic                    i_bready
);

    // =======================================================================
    // Control
    // =======================================================================
    logic w_rd_start;
    logic w_wr_start;
    logic w_rd_done;
    logic w_wr_done;

    // Lane side
    sram_axi4_pkg::strb_t     w_lane_we;
    sram_axi4_pkg::word_idx_t w_lane_widx;
    sram_axi4_pkg::data_t     w_lane_wdata;
    logic                     w_lane_ren;
    sram_axi4_pkg::word_idx_t w_lane_ridx;
    sram_axi4_pkg::data_t     w_lane_rdata;

    sram_txn_arbiter u_arbiter (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_arvalid  (i_arvalid),
        .i_awvalid  (i_awvalid),
        .i_rd_done  (w_rd_done),
        .i_wr_done  (w_wr_done),
        .o_arready  (o_arready),
        .o_awready  (o_awready),
        .o_rd_start (w_rd_start),
        .o_wr_start (w_wr_start)
    );

    // =======================================================================
    // Channels
    // =======================================================================
    sram_write_chan u_write_chan (
        .i_aclk       (i_aclk),
        .i_areset_n   (i_areset_n),
        .i_start      (w_wr_start),
        .i_awid       (i_awid),
        .i_awaddr     (i_awaddr),
        .i_awlen      (i_awlen),
        .i_awburst    (i_awburst),
        .i_wdata      (i_wdata),
        .i_wstrb      (i_wstrb),
        .i_wvalid     (i_wvalid),
        .i_bready     (i_bready),
        .o_wready     (o_wready),
        .o_bid        (o_bid),
        .o_bvalid     (o_bvalid),
        .o_done       (w_wr_done),
        .o_lane_we    (w_lane_we),
        .o_lane_idx   (w_lane_widx),
        .o_lane_wdata (w_lane_wdata)
    );

    sram_read_chan u_read_chan (
        .i_aclk       (i_aclk),
        .i_areset_n   (i_areset_n),
        .i_start      (w_rd_start),
        .i_arid       (i_arid),
        .i_araddr     (i_araddr),
        .i_arlen      (i_arlen),
        .i_arburst    (i_arburst),
        .i_rready     (i_rready),
        .i_lane_rdata (w_lane_rdata),
        .o_rid        (o_rid),
        .o_rdata      (o_rdata),
        .o_rlast      (o_rlast),
        .o_rvalid     (o_rvalid),
        .o_done       (w_rd_done),
        .o_lane_ren   (w_lane_ren),
        .o_lane_idx   (w_lane_ridx)
    );

    // =======================================================================
    // Storage
    // =======================================================================
    // Lane k holds byte k of every word
    for (genvar k = 0; k < `SRAM_LANES; k++) begin : g_lane
        sram_byte_lane u_lane (
            .i_aclk  (i_aclk),
            .i_we    (w_lane_we[k]),
            .i_widx  (w_lane_widx),
            .i_wdata (w_lane_wdata[k*8 +: 8]),
            .i_re    (w_lane_ren),
            .i_ridx  (w_lane_ridx),
            .o_rdata (w_lane_rdata[k*8 +: 8])
        );
    end

endmodule

/* design/sram_axi4_cfg.svh */
// ===========================================================================
// SRAM AXI4 widths and depth
// ===========================================================================

`ifndef SRAM_AXI4_CFG_SVH
`define SRAM_AXI4_CFG_SVH

// One beat is a full 64-bit word split into byte lanes
`define SRAM_DATA_W      64
`define SRAM_LANES       8

// 2 KB of storage, byte addressed on the bus
`define SRAM_ADDR_W      11
`define SRAM_WORD_ADDR_W 8
`define SRAM_DEPTH       256

// Transaction fields
`define SRAM_ID_W        4
`define SRAM_LEN_W       8

`endif

/* design/sram_axi4_pkg.sv */
// ===========================================================================
// SRAM AXI4 shared types
// ===========================================================================

`include "sram_axi4_cfg.svh"

package sram_axi4_pkg;

    // Bus byte address, low three bits unused
    typedef logic [`SRAM_ADDR_W-1:0] addr_t;

    // Word index into the byte lanes
    typedef logic [`SRAM_WORD_ADDR_W-1:0] word_idx_t;

    // Beat payload and its byte strobes
    typedef logic [`SRAM_DATA_W-1:0] data_t;
    typedef logic [`SRAM_LANES-1:0] strb_t;

    // One lane's byte
    typedef logic [7:0] byte_t;

    // Transaction ID, echoed on R and B
    typedef logic [`SRAM_ID_W-1:0] id_t;

    // Beats minus one
    typedef logic [`SRAM_LEN_W-1:0] len_t;

    // AXI burst encodings
    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2
    } burst_e;

endpackage

/* design/sram_byte_lane.sv */
// ===========================================================================
// SRAM byte lane
// ===========================================================================

`include "sram_axi4_cfg.svh"

module sram_byte_lane (
    input  logic                       i_aclk,
    input  logic                       i_we,
    input  sram_axi4_pkg::word_idx_t   i_widx,
    input  sram_axi4_pkg::byte_t       i_wdata,
    input  logic                       i_re,
    input  sram_axi4_pkg::word_idx_t   i_ridx,
    output sram_axi4_pkg::byte_t       o_rdata
);

    // Contents undefined after reset
    sram_axi4_pkg::byte_t r_mem [0:`SRAM_DEPTH-1];

    always_ff @(posedge i_aclk) begin
        if (i_we) begin
            r_mem[i_widx] <= i_wdata;
        end
    end

    // Registered read, output holds when not enabled
    always_ff @(posedge i_aclk) begin
        if (i_re) begin
            o_rdata <= r_mem[i_ridx];
        end
    end

endmodule

/* design/sram_read_chan.sv */
// ===========================================================================
// AXI4 read data channel
// ===========================================================================

module sram_read_chan (
    input  logic                       i_aclk,
    input  logic                       i_areset_n,
    input  logic                       i_start,
    input  sram_axi4_pkg::id_t         i_arid,
    input  sram_axi4_pkg::addr_t       i_araddr,
    input  sram_axi4_pkg::len_t        i_arlen,
    input  sram_axi4_pkg::burst_e      i_arburst,
    input  logic                       i_rready,
    input  sram_axi4_pkg::data_t       i_lane_rdata,
    output sram_axi4_pkg::id_t         o_rid,
    output sram_axi4_pkg::data_t       o_rdata,
    output logic                       o_rlast,
    output logic                       o_rvalid,
    output logic                       o_done,
    output logic                       o_lane_ren,
    output sram_axi4_pkg::word_idx_t   o_lane_idx
);

    // Issue a lane read, wait for the lane register, then present the beat
    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_ISSUE   = 2'd1;
    localparam logic [1:0] S_WAIT    = 2'd2;
    localparam logic [1:0] S_PRESENT = 2'd3;

    logic [1:0] r_state;
    logic       w_rbeat;
    logic       w_last;

    assign w_rbeat    = o_rvalid && i_rready;
    assign o_done     = w_rbeat && o_rlast;
    assign o_lane_ren = (r_state == S_ISSUE);

    burst_addr_tracker u_tracker (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (i_start),
        .i_addr     (i_araddr),
        .i_len      (i_arlen),
        .i_burst    (i_arburst),
        .i_step     (w_rbeat),
        .o_idx      (o_lane_idx),
        .o_last     (w_last)
    );

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state  <= S_IDLE;
            o_rvalid <= 1'b0;
        end else begin
            case (r_state)
                S_IDLE: begin
                    if (i_start) r_state <= S_ISSUE;
                end
                S_ISSUE: begin
                    r_state <= S_WAIT;
                end
                S_WAIT: begin
                    r_state  <= S_PRESENT;
                    o_rvalid <= 1'b1;
                end
                default: begin
                    // Hold the beat until the master takes it
                    if (w_rbeat) begin
                        o_rvalid <= 1'b0;
                        r_state  <= o_rlast ? S_IDLE : S_ISSUE;
                    end
                end
            endcase
        end
    end

    // Beat payload, stable while rvalid waits
    always_ff @(posedge i_aclk) begin
        if (i_start) begin
            o_rid <= i_arid;
        end
        if (r_state == S_WAIT) begin
            o_rdata <= i_lane_rdata;
            o_rlast <= w_last;
        end
    end

endmodule

/* design/sram_txn_arbiter.sv */
// ===========================================================================
// Read/write transaction arbiter
// ===========================================================================

module sram_txn_arbiter (
    input  logic i_aclk,
    input  logic i_areset_n,
    input  logic i_arvalid,
    input  logic i_awvalid,
    input  logic i_rd_done,
    input  logic i_wr_done,
    output logic o_arready,
    output logic o_awready,
    output logic o_rd_start,
    output logic o_wr_start
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_READ  = 2'd1;
    localparam logic [1:0] S_WRITE = 2'd2;

    logic [1:0] r_state;

    // Reads win, so AW is only offered when no AR is pending
    assign o_arready  = (r_state == S_IDLE);
    assign o_awready  = (r_state == S_IDLE) && !i_arvalid;
    assign o_rd_start = i_arvalid && o_arready;
    assign o_wr_start = i_awvalid && o_awready;

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state <= S_IDLE;
        end else begin
            case (r_state)
                S_IDLE: begin
                    if (o_rd_start) begin
                        r_state <= S_READ;
                    end else if (o_wr_start) begin
                        r_state <= S_WRITE;
                    end
                end
                S_READ: begin
                    if (i_rd_done) begin
                        r_state <= S_IDLE;
                    end
                end
                S_WRITE: begin
                    if (i_wr_done) begin
                        r_state <= S_IDLE;
                    end
                end
                default: begin
                    r_state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/sram_write_chan.sv */
// ===========================================================================
// AXI4 write data and response channel
// ===========================================================================

module sram_write_chan (
    input  logic                       i_aclk,
    input  logic                       i_areset_n,
    input  logic                       i_start,
    input  sram_axi4_pkg::id_t         i_awid,
    input  sram_axi4_pkg::addr_t       i_awaddr,
    input  sram_axi4_pkg::len_t        i_awlen,
    input  sram_axi4_pkg::burst_e      i_awburst,
    input  sram_axi4_pkg::data_t       i_wdata,
    input  sram_axi4_pkg::strb_t       i_wstrb,
    input  logic                       i_wvalid,
    input  logic                       i_bready,
    output logic                       o_wready,
    output sram_axi4_pkg::id_t         o_bid,
    output logic                       o_bvalid,
    output logic                       o_done,
    output sram_axi4_pkg::strb_t       o_lane_we,
    output sram_axi4_pkg::word_idx_t   o_lane_idx,
    output sram_axi4_pkg::data_t       o_lane_wdata
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_DATA = 2'd1;
    localparam logic [1:0] S_RESP = 2'd2;

    logic [1:0] r_state;
    logic       w_wbeat;
    logic       w_last;

    assign o_wready = (r_state == S_DATA);
    assign o_bvalid = (r_state == S_RESP);
    assign w_wbeat  = i_wvalid && o_wready;
    assign o_done   = o_bvalid && i_bready;

    // Lane enables only on an accepted beat
    assign o_lane_we    = w_wbeat ? i_wstrb : '0;
    assign o_lane_wdata = i_wdata;

    burst_addr_tracker u_tracker (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_load     (i_start),
        .i_addr     (i_awaddr),
        .i_len      (i_awlen),
        .i_burst    (i_awburst),
        .i_step     (w_wbeat),
        .o_idx      (o_lane_idx),
        .o_last     (w_last)
    );

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state <= S_IDLE;
        end else begin
            case (r_state)
                S_IDLE:  if (i_start) r_state <= S_DATA;
                // Beats are counted, wlast is not looked at
                S_DATA:  if (w_wbeat && w_last) r_state <= S_RESP;
                S_RESP:  if (i_bready) r_state <= S_IDLE;
                default: r_state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_start) begin
            o_bid <= i_awid;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the SRAM AXI4 testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_sram_axi4 \
    -f sram_axi4.f \
    -o tb_sram_axi4

./obj_dir/tb_sram_axi4 > "$LOG"
cat "$LOG"

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "Simulation result: passed"
    exit 0
else
    echo "Simulation result: failed"
    exit 1
fi

/* sram_axi4.f */
+incdir+design
+incdir+tb
design/sram_axi4_pkg.sv
design/burst_addr_tracker.sv
design/sram_txn_arbiter.sv
design/sram_write_chan.sv
design/sram_read_chan.sv
design/sram_byte_lane.sv
design/sram_axi4.sv
tb/tb_sram_axi4.sv

/* tb/tb_sram_axi4_tasks.svh */
// ===========================================================================
// Testbench bus tasks, checks and memory model
// ===========================================================================

`ifndef TB_SRAM_AXI4_TASKS_SVH
`define TB_SRAM_AXI4_TASKS_SVH

// Byte-wise model of the SRAM, word w lane k at w*LANES+k
sram_axi4_pkg::byte_t ref_mem [0:`SRAM_DEPTH*`SRAM_LANES-1];

// Payload for the next write burst
sram_axi4_pkg::data_t beat_data [$];
sram_axi4_pkg::strb_t beat_strb [$];

int     mismatch_count = 0;
int     other_count    = 0;
bit     rd_busy        = 1'b0;
integer seed           = 98818;

// ===========================================================================
// Reference model
// ===========================================================================

// AXI burst rule on word indices
function automatic sram_axi4_pkg::word_idx_t next_word(
    input sram_axi4_pkg::word_idx_t cur,
    input sram_axi4_pkg::len_t      len,
    input sram_axi4_pkg::burst_e    burst
);
    int block;
    int offs;
    block = int'(len) + 1;
    offs  = int'(cur) % block;
    case (burst)
        sram_axi4_pkg::BURST_FIXED: next_word = cur;
        sram_axi4_pkg::BURST_WRAP: begin
            // Stay inside the aligned block of len+1 words
            next_word = sram_axi4_pkg::word_idx_t'(int'(cur) - offs + (offs + 1) % block);
        end
        default: next_word = cur + 1'b1;
    endcase
endfunction

function automatic sram_axi4_pkg::data_t model_word(input sram_axi4_pkg::word_idx_t idx);
    sram_axi4_pkg::data_t word;
    int k;
    for (k = 0; k < `SRAM_LANES; k++) begin
        word[k*8 +: 8] = ref_mem[int'(idx)*`SRAM_LANES + k];
    end
    return word;
endfunction

task automatic model_write(
    input sram_axi4_pkg::word_idx_t idx,
    input sram_axi4_pkg::data_t     data,
    input sram_axi4_pkg::strb_t     strb
);
    int k;
    for (k = 0; k < `SRAM_LANES; k++) begin
        if (strb[k]) begin
            ref_mem[int'(idx)*`SRAM_LANES + k] = data[k*8 +: 8];
        end
    end
endtask

function automatic sram_axi4_pkg::data_t rand_word();
    return {$random(seed), $random(seed)};
endfunction

task automatic fill_beats(input int n, input sram_axi4_pkg::strb_t strb);
    int b;
    beat_data.delete();
    beat_strb.delete();
    for (b = 0; b < n; b++) begin
        beat_data.push_back(rand_word());
        beat_strb.push_back(strb);
    end
endtask

// ===========================================================================
// Compare tasks
// ===========================================================================
task automatic check_data(
    input string                name,
    input sram_axi4_pkg::data_t got,
    input sram_axi4_pkg::data_t exp
);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_id(
    input string              name,
    input sram_axi4_pkg::id_t got,
    input sram_axi4_pkg::id_t exp
);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// ===========================================================================
// Bus tasks
// ===========================================================================

// AW, then len+1 W beats from beat_data/beat_strb, then B after a delay
task automatic write_burst(
    input sram_axi4_pkg::id_t     id,
    input sram_axi4_pkg::addr_t   addr,
    input sram_axi4_pkg::len_t    len,
    input sram_axi4_pkg::burst_e  burst,
    input int                     bready_delay
);
    sram_axi4_pkg::word_idx_t idx;
    int b;
    idx = addr[`SRAM_ADDR_W-1:3];
    @(posedge aclk);
    awid    <= id;
    awaddr  <= addr;
    awlen   <= len;
    awburst <= burst;
    awvalid <= 1'b1;
    do begin
        @(posedge aclk);
    end while (!awready);
    if (rd_busy) begin
        other_count++;
        $display("Error at %0d ns: write address accepted during a read burst", $time);
    end
    awvalid <= 1'b0;
    for (b = 0; b <= int'(len); b++) begin
        wdata  <= beat_data[b];
        wstrb  <= beat_strb[b];
        wvalid <= 1'b1;
        do begin
            @(posedge aclk);
        end while (!wready);
        model_write(idx, beat_data[b], beat_strb[b]);
        idx = next_word(idx, len, burst);
    end
    wvalid <= 1'b0;
    do begin
        @(posedge aclk);
    end while (!bvalid);
    repeat (bready_delay) begin
        @(posedge aclk);
        if (!bvalid) begin
            other_count++;
            $display("Error at %0d ns: bvalid dropped while bready was low", $time);
        end
    end
    bready <= 1'b1;
    @(posedge aclk);
    if (!bvalid) begin
        other_count++;
        $display("Error at %0d ns: no write response when bready rose", $time);
    end
    check_id("o_bid", bid, id);
    bready <= 1'b0;
    @(posedge aclk);
    check_flag("o_awready after B", awready, 1'b1);
endtask

// AR, then len+1 R beats checked against the model as it stood at the call
task automatic read_burst(
    input sram_axi4_pkg::id_t     id,
    input sram_axi4_pkg::addr_t   addr,
    input sram_axi4_pkg::len_t    len,
    input sram_axi4_pkg::burst_e  burst,
    input bit                     stall
);
    sram_axi4_pkg::data_t     exp_q [$];
    sram_axi4_pkg::data_t     held_data;
    sram_axi4_pkg::word_idx_t idx;
    logic                     held_last;
    bit                       held;
    int                       beat;
    idx = addr[`SRAM_ADDR_W-1:3];
    for (beat = 0; beat <= int'(len); beat++) begin
        exp_q.push_back(model_word(idx));
        idx = next_word(idx, len, burst);
    end
    rd_busy = 1'b1;
    @(posedge aclk);
    arid    <= id;
    araddr  <= addr;
    arlen   <= len;
    arburst <= burst;
    arvalid <= 1'b1;
    do begin
        @(posedge aclk);
    end while (!arready);
    arvalid <= 1'b0;
    rready  <= stall ? (($random(seed) & 3) == 0) : 1'b1;
    held = 1'b0;
    beat = 0;
    while (beat <= int'(len)) begin
        @(posedge aclk);
        if (rvalid && rready) begin
            check_data("o_rdata", rdata, exp_q[beat]);
            check_flag("o_rlast", rlast, beat == int'(len));
            check_id("o_rid", rid, id);
            held = 1'b0;
            beat++;
        end else if (rvalid) begin
            // Beat waiting on rready must not change
            if (held) begin
                check_data("o_rdata (held)", rdata, held_data);
                check_flag("o_rlast (held)", rlast, held_last);
            end
            held      = 1'b1;
            held_data = rdata;
            held_last = rlast;
        end else if (held) begin
            other_count++;
            $display("Error at %0d ns: rvalid dropped before rready", $time);
            held = 1'b0;
        end
        if (stall) begin
            rready <= ($random(seed) & 3) == 0;
        end
    end
    rready  <= 1'b0;
    rd_busy = 1'b0;
    @(posedge aclk);
    check_flag("o_arready after R", arready, 1'b1);
endtask

`endif

/* tb/tb_sram_axi4.sv */
// ===========================================================================
// SRAM AXI4 testbench
// ===========================================================================

`include "sram_axi4_cfg.svh"

module tb_sram_axi4;

    timeunit 1ns;
    timeprecision 1ps;

    // Tests take about 600 cycles, the longest being the stalled reads
    localparam int TIMEOUT_CYCLES = 4000;

    logic                     aclk;
    logic                     areset_n;
    sram_axi4_pkg::id_t       arid;
    sram_axi4_pkg::addr_t     araddr;
    sram_axi4_pkg::len_t      arlen;
    sram_axi4_pkg::burst_e    arburst;
    logic                     arvalid;
    logic                     arready;
    sram_axi4_pkg::id_t       rid;
    sram_axi4_pkg::data_t     rdata;
    logic                     rlast;
    logic                     rvalid;
    logic                     rready;
    sram_axi4_pkg::id_t       awid;
    sram_axi4_pkg::addr_t     awaddr;
    sram_axi4_pkg::len_t      awlen;
    sram_axi4_pkg::burst_e    awburst;
    logic                     awvalid;
    logic                     awready;
    sram_axi4_pkg::data_t     wdata;
    sram_axi4_pkg::strb_t     wstrb;
    logic                     wvalid;
    logic                     wready;
    sram_axi4_pkg::id_t       bid;
    logic                     bvalid;
    logic                     bready;
    int                       cycle_cnt = 0;

    `include "tb_sram_axi4_tasks.svh"

    sram_axi4 i_dut (
        .i_aclk     (aclk),
        .i_areset_n (areset_n),
        .i_arid     (arid),
        .i_araddr   (araddr),
        .i_arlen    (arlen),
        .i_arburst  (arburst),
        .i_arvalid  (arvalid),
        .o_arready  (arready),
        .o_rid      (rid),
        .o_rdata    (rdata),
        .o_rlast    (rlast),
        .o_rvalid   (rvalid),
        .i_rready   (rready),
        .i_awid     (awid),
        .i_awaddr   (awaddr),
        .i_awlen    (awlen),
        .i_awburst  (awburst),
        .i_awvalid  (awvalid),
        .o_awready  (awready),
        .i_wdata    (wdata),
        .i_wstrb    (wstrb),
        .i_wvalid   (wvalid),
        .o_wready   (wready),
        .o_bid      (bid),
        .o_bvalid   (bvalid),
        .i_bready   (bready)
    );

    always #4 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // =======================================================================
    // Directed tests
    // =======================================================================
    task automatic reset_levels();
        @(posedge aclk);
        check_flag("o_arready", arready, 1'b1);
        check_flag("o_awready", awready, 1'b1);
        check_flag("o_rvalid", rvalid, 1'b0);
        check_flag("o_wready", wready, 1'b0);
        check_flag("o_bvalid", bvalid, 1'b0);
    endtask

    task automatic incr_bursts();
        fill_beats(1, 8'hFF);
        write_burst(4'h3, 11'h040, 8'd0, sram_axi4_pkg::BURST_INCR, 0);
        read_burst(4'h5, 11'h040, 8'd0, sram_axi4_pkg::BURST_INCR, 1'b0);
        fill_beats(8, 8'hFF);
        write_burst(4'hA, 11'h100, 8'd7, sram_axi4_pkg::BURST_INCR, 0);
        read_burst(4'h6, 11'h100, 8'd7, sram_axi4_pkg::BURST_INCR, 1'b0);
    endtask

    task automatic partial_strobes();
        fill_beats(2, 8'hFF);
        write_burst(4'h1, 11'h200, 8'd1, sram_axi4_pkg::BURST_INCR, 0);
        fill_beats(1, 8'h0F);
        write_burst(4'h2, 11'h200, 8'd0, sram_axi4_pkg::BURST_INCR, 0);
        fill_beats(1, 8'hA5);
        write_burst(4'h3, 11'h208, 8'd0, sram_axi4_pkg::BURST_INCR, 0);
        read_burst(4'h4, 11'h200, 8'd1, sram_axi4_pkg::BURST_INCR, 1'b0);
    endtask

    task automatic wrap_and_fixed();
        // Block of words 0x60 to 0x63, wrap starts at 0x62
        fill_beats(4, 8'hFF);
        write_burst(4'h7, 11'h300, 8'd3, sram_axi4_pkg::BURST_INCR, 0);
        fill_beats(4, 8'hFF);
        write_burst(4'h8, 11'h310, 8'd3, sram_axi4_pkg::BURST_WRAP, 0);
        read_burst(4'h9, 11'h300, 8'd3, sram_axi4_pkg::BURST_INCR, 1'b0);
        // One word merged by four FIXED beats
        fill_beats(1, 8'hFF);
        write_burst(4'hB, 11'h380, 8'd0, sram_axi4_pkg::BURST_INCR, 0);
        fill_beats(4, 8'h00);
        beat_strb[0] = 8'h03;
        beat_strb[1] = 8'h3C;
        beat_strb[2] = 8'h81;
        beat_strb[3] = 8'h50;
        write_burst(4'hC, 11'h380, 8'd3, sram_axi4_pkg::BURST_FIXED, 0);
        read_burst(4'hD, 11'h380, 8'd2, sram_axi4_pkg::BURST_FIXED, 1'b0);
    endtask

    task automatic back_pressure();
        fill_beats(16, 8'hFF);
        write_burst(4'hE, 11'h400, 8'd15, sram_axi4_pkg::BURST_INCR, 5);
        read_burst(4'hF, 11'h400, 8'd15, sram_axi4_pkg::BURST_INCR, 1'b1);
        read_burst(4'h2, 11'h420, 8'd7, sram_axi4_pkg::BURST_WRAP, 1'b1);
    endtask

    task automatic read_priority();
        fill_beats(2, 8'hFF);
        write_burst(4'h1, 11'h500, 8'd1, sram_axi4_pkg::BURST_INCR, 0);
        fill_beats(2, 8'hFF);
        // AR and AW raised together, read sees the old words
        fork
            read_burst(4'h3, 11'h500, 8'd1, sram_axi4_pkg::BURST_INCR, 1'b0);
            write_burst(4'h4, 11'h500, 8'd1, sram_axi4_pkg::BURST_INCR, 2);
        join
        read_burst(4'h5, 11'h500, 8'd1, sram_axi4_pkg::BURST_INCR, 1'b0);
    endtask

    // =======================================================================
    // Sequence
    // =======================================================================
    initial begin
        aclk     = 1'b0;
        areset_n <= 1'b0;
        arid     <= '0;
        araddr   <= '0;
        arlen    <= '0;
        arburst  <= sram_axi4_pkg::BURST_INCR;
        arvalid  <= 1'b0;
        rready   <= 1'b0;
        awid     <= '0;
        awaddr   <= '0;
        awlen    <= '0;
        awburst  <= sram_axi4_pkg::BURST_INCR;
        awvalid  <= 1'b0;
        wdata    <= '0;
        wstrb    <= '0;
        wvalid   <= 1'b0;
        bready   <= 1'b0;
        repeat (5) @(posedge aclk);
        areset_n <= 1'b1;
        reset_levels();
        incr_bursts();
        partial_strobes();
        wrap_and_fixed();
        back_pressure();
        read_priority();
        @(posedge aclk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
